//--- test/decode_golden.txt
# test rst jmp_rst brx_rst input_flush output_flush hazard miss prg_data
# expected: strobes alu_op regf_wren dest | i_field h_en l_en src pc_brxt | flow(jmp brx call ret) | mask(ctrl dest fields)
1 0 0 0 0 0 0 0 0319 00000000 7 0 00 000 0 0 00 0 0000 101
1 0 0 0 0 0 0 0 1338 01100000 0 1 19 319 0 0 18 0 0000 111
1 0 0 0 0 0 0 0 23DA 10010000 8 1 18 338 0 0 19 1 0000 111
1 0 0 0 0 0 0 0 381B 00001100 1 1 1A 3DA 0 0 1E 0 0000 111
1 0 0 0 0 0 0 0 4434 00000100 9 1 1B 01B 1 0 00 1 0000 111
1 0 0 0 0 0 0 0 5055 00000010 2 1 14 034 0 1 01 0 0000 111
1 0 0 0 0 0 0 0 6076 00000010 A 1 15 055 0 0 02 1 0000 111
1 0 0 0 0 0 0 0 7081 00000001 3 1 16 076 0 0 03 0 0000 111
1 0 0 0 0 0 0 0 80A2 00000000 B 1 01 081 0 0 04 1 0000 111
1 0 0 0 0 0 0 0 90C3 00000000 4 1 02 0A2 0 0 05 0 0000 111
1 0 0 0 0 0 0 0 A0E4 00000000 5 1 03 0C3 0 0 06 1 0000 111
1 0 0 0 0 0 0 0 C000 00000000 6 1 04 0E4 0 0 07 0 0000 111
2 0 0 0 0 0 0 0 B800 00000000 7 0 00 000 0 0 00 0 0000 101
2 0 0 0 0 0 0 0 B100 00000000 7 1 11 000 1 0 00 1 0010 111
2 0 0 0 0 0 0 0 B200 00000000 7 0 00 100 0 0 08 1 1000 101
2 0 0 0 0 0 0 0 C400 00000000 7 0 00 200 0 0 10 1 0001 101
2 0 0 0 0 0 0 0 D000 00000000 7 0 00 000 0 1 00 0 0100 101
2 0 0 0 0 0 0 0 C000 00000000 7 0 00 000 0 0 00 1 0100 101
2 0 0 0 0 0 0 0 C000 00000000 7 0 00 000 0 0 00 0 0000 101
2 0 0 0 0 0 0 0 B100 00000000 7 0 00 000 0 0 00 0 0000 101
2 0 0 0 0 0 0 0 D000 00000000 7 0 00 100 0 0 08 1 1000 101
2 0 0 0 0 0 1 0 C000 00000000 7 0 00 100 0 0 08 1 1000 101
2 0 1 0 0 0 1 0 C000 00000000 7 0 00 100 0 0 08 1 0000 101
2 0 0 0 0 0 0 0 C000 00000000 7 0 00 000 0 0 00 1 0100 101
2 0 0 0 0 0 1 0 C000 00000000 7 0 00 000 0 0 00 1 0100 101
2 0 0 1 0 0 1 0 C000 00000000 7 0 00 000 0 0 00 1 0000 101
2 0 0 0 0 0 0 0 C000 00000000 7 0 00 000 0 0 00 0 0000 101
3 0 0 0 0 0 0 0 E2AB 00000000 7 0 00 000 0 0 00 0 0000 101
3 0 0 0 0 0 0 0 F3C5 00000000 7 1 12 2AB 0 0 15 0 0000 111
3 0 0 0 0 0 0 0 F300 00001000 F 0 00 3C5 0 0 1E 1 0000 101
3 0 0 0 0 0 0 0 C000 01000000 F 0 00 300 0 0 18 1 0000 101
4 0 0 0 0 0 0 0 0319 00000000 7 0 00 000 0 0 00 0 0000 101
4 0 0 0 0 0 1 0 1338 00000000 7 0 00 000 0 0 00 0 0000 101
4 0 0 0 0 0 1 0 23DA 00000000 7 0 00 000 0 0 00 0 0000 101
4 0 0 0 0 0 0 0 381B 01100000 0 1 19 319 0 0 18 0 0000 111
4 0 0 0 0 0 0 0 C000 10010000 8 1 18 338 0 0 19 1 0000 111
4 0 0 0 0 0 0 0 C000 00000000 7 0 00 000 0 0 00 0 0000 101
5 0 0 0 0 0 0 0 0319 00000000 7 0 00 000 0 0 00 0 0000 101
5 0 0 0 0 0 0 1 1338 01100000 0 1 19 319 0 0 18 0 0000 111
5 0 0 0 0 0 0 1 23DA 00000000 7 0 00 000 0 0 00 0 0000 101
5 0 0 0 0 0 0 0 4434 00000000 7 0 00 000 0 0 00 0 0000 101
5 0 0 0 0 0 0 0 5055 00000000 7 0 00 000 0 0 00 0 0000 101
5 0 0 0 0 0 0 0 C000 00000010 A 1 15 055 0 0 02 1 0000 111
5 0 0 0 0 0 0 0 6076 00000000 7 0 00 000 0 0 00 0 0000 101
5 0 0 0 1 0 0 0 7081 00000001 3 1 16 076 0 0 03 0 0000 111
5 0 0 0 0 0 0 0 80A2 00000000 7 0 00 000 0 0 00 0 0000 101
5 0 0 0 0 0 0 0 C000 00000000 4 1 02 0A2 0 0 05 0 0000 111
5 0 0 0 0 0 0 0 0319 00000000 7 0 00 000 0 0 00 0 0000 101
5 0 0 0 0 0 0 0 B200 01100000 0 1 19 319 0 0 18 0 0000 111
5 0 0 0 0 1 0 0 1338 00000000 7 0 00 319 0 0 18 0 0000 101
5 0 0 0 0 0 0 0 C000 10010000 8 1 18 338 0 0 19 1 0000 111
5 0 0 0 0 0 0 0 C000 00000000 7 0 00 000 0 0 00 0 0000 101
6 0 0 0 0 0 0 0 0319 00000000 7 0 00 000 0 0 00 0 0000 101
6 1 0 0 0 0 0 0 C000 00000000 7 0 00 000 0 0 00 0 0000 101
6 1 0 0 0 0 0 0 C000 00000000 7 0 00 000 0 0 00 0 0000 101
6 0 0 0 0 0 0 0 C000 00000000 7 0 00 000 0 0 00 0 0000 101

//--- vlog.f
+incdir+design
design/decode_pkg.sv
design/instr_latch.sv
design/operand_decode.sv
design/flow_decode.sv
design/decode_unit.sv
test/decode_properties.sv
test/tb_decode_unit.sv

//--- Makefile
SRCS := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: run clean

obj_dir/Vtb_decode_unit: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_decode_unit -f vlog.f

run: obj_dir/Vtb_decode_unit test/decode_golden.txt
	out="$$(./obj_dir/Vtb_decode_unit)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- test/tb_decode_unit.sv
`timescale 1ns/1ps

`include "decode_params.svh"

module tb_decode_unit
	import decode_pkg::*;
();

	localparam int MAX_CYCLES = 400;
	localparam int IDLE_WAIT = 20;

	logic clk;
	logic rst;
	logic jmp_rst;
	logic brx_rst;
	logic input_flush;
	logic output_flush;
	logic hazard;
	logic p_cache_miss;
	instr_t prg_data;
	exec_ctrl_t exec;
	instr_fields_t fields;
	flow_ctrl_t flow;

	int fd;
	int status;
	int n_read;
	int cycles;
	int wait_cnt;
	int n_checks;
	int n_errors;
	int n_tests;
	int cur_test;
	int test_start_errs;
	logic timed_out;
	string line;

	// one golden line with inputs then expected values
	int g_test;
	logic g_rst;
	logic g_jr;
	logic g_br;
	logic g_if;
	logic g_of;
	logic g_hz;
	logic g_ms;
	instr_t g_prg;
	logic [7:0] g_strb;
	logic [3:0] g_alu;
	logic g_wr;
	reg_addr_t g_dest;
	imm_t g_imm;
	logic g_h;
	logic g_l;
	reg_addr_t g_src;
	logic g_bt;
	logic [3:0] g_flow;
	// control, dest_waddr, fields
	logic [2:0] g_mask;

	// expected values of the line driven one cycle earlier
	logic pend_valid;
	int pend_test;
	exec_ctrl_t pend_exec;
	exec_ctrl_t pend_exec_mask;
	instr_fields_t pend_fields;
	logic pend_fields_en;
	flow_ctrl_t pend_flow;

	decode_unit u_decode_unit (
		.clk(clk),
		.rst(rst),
		.jmp_rst(jmp_rst),
		.brx_rst(brx_rst),
		.input_flush(input_flush),
		.output_flush(output_flush),
		.hazard(hazard),
		.p_cache_miss(p_cache_miss),
		.prg_data(prg_data),
		.exec(exec),
		.fields(fields),
		.flow(flow)
	);

	always #20 clk = ~clk;

	task automatic check_exec(input exec_ctrl_t got, input exec_ctrl_t exp,
		input exec_ctrl_t mask);
		n_checks++;
		if ((got & mask) !== (exp & mask))
		begin
			n_errors++;
			$display("Error at %0t: exec got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_fields(input instr_fields_t got, input instr_fields_t exp,
		input logic en);
		if (en)
		begin
			n_checks++;
			if (got !== exp)
			begin
				n_errors++;
				$display("Error at %0t: fields got %h expected %h", $time, got, exp);
			end
		end
	endtask

	task automatic check_flow(input flow_ctrl_t got, input flow_ctrl_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("Error at %0t: flow got %b expected %b", $time, got, exp);
		end
	endtask

	// summary line for the test that just ended
	task automatic close_test();
		if (cur_test >= 0)
		begin
			n_tests++;
			$display("test %0d done, %0d errors", cur_test, n_errors - test_start_errs);
		end
	endtask

	// outputs against the held expectations of one golden line
	task automatic compare_line();
		if (pend_test != cur_test)
		begin
			close_test();
			cur_test = pend_test;
			test_start_errs = n_errors;
		end
		check_exec(exec, pend_exec, pend_exec_mask);
		check_fields(fields, pend_fields, pend_fields_en);
		check_flow(flow, pend_flow);
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		jmp_rst = 1'b0;
		brx_rst = 1'b0;
		input_flush = 1'b0;
		output_flush = 1'b0;
		hazard = 1'b0;
		p_cache_miss = 1'b0;
		prg_data = `DEC_NOP_WORD;
		n_checks = 0;
		n_errors = 0;
		n_tests = 0;
		cur_test = -1;
		test_start_errs = 0;
		cycles = 0;
		timed_out = 1'b0;
		pend_valid = 1'b0;

		fd = $fopen("test/decode_golden.txt", "r");
		if (fd == 0)
		begin
			n_errors++;
			$display("could not open test/decode_golden.txt");
		end
		else
		begin
			repeat (5) @(posedge clk);
			#2;
			rst = 1'b0;
			// decode must come out of reset idle
			wait_cnt = 0;
			while (!(exec.alu_op == ALU_NOP && !exec.regf_wren && flow == 4'b0000)
				&& !timed_out)
			begin
				if (wait_cnt >= IDLE_WAIT)
				begin
					timed_out = 1'b1;
					n_errors++;
					$display("outputs never went idle after reset");
				end
				else
				begin
					@(posedge clk);
					#1;
					wait_cnt++;
				end
			end

			while (!$feof(fd) && !timed_out)
			begin
				status = $fgets(line, fd);
				n_read = 0;
				if (status > 0)
					n_read = $sscanf(line,
						"%d %b %b %b %b %b %b %b %h %b %h %b %h %h %b %b %h %b %b %b",
						g_test, g_rst, g_jr, g_br, g_if, g_of, g_hz, g_ms, g_prg,
						g_strb, g_alu, g_wr, g_dest, g_imm, g_h, g_l, g_src, g_bt,
						g_flow, g_mask);
				// comment lines do not parse
				if (n_read == 20)
				begin
					if (cycles >= MAX_CYCLES)
					begin
						timed_out = 1'b1;
						n_errors++;
						$display("golden file ran past %0d cycles, stopped", MAX_CYCLES);
					end
					else
					begin
						@(posedge clk);
						#2;
						rst = g_rst;
						jmp_rst = g_jr;
						brx_rst = g_br;
						input_flush = g_if;
						output_flush = g_of;
						hazard = g_hz;
						p_cache_miss = g_ms;
						prg_data = g_prg;
						// just before the next edge
						#37;
						if (pend_valid)
							compare_line();
						// a line's expected outputs follow the edge that samples its inputs
						pend_valid = 1'b1;
						pend_test = g_test;
						pend_exec = exec_ctrl_t'({g_strb, g_alu, g_wr, g_dest});
						pend_exec_mask = exec_ctrl_t'({{13{g_mask[2]}}, {5{g_mask[1]}}});
						pend_fields = instr_fields_t'({g_imm, g_h, g_l, g_src, g_bt});
						pend_fields_en = g_mask[0];
						pend_flow = flow_ctrl_t'(g_flow);
						cycles++;
					end
				end
			end
			// last line settles one edge later
			if (pend_valid && !timed_out)
			begin
				@(posedge clk);
				#39;
				compare_line();
			end
			close_test();
			$fclose(fd);
		end

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule : tb_decode_unit

//--- test/decode_properties.sv
`timescale 1ns/1ps

module decode_properties
	import decode_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic hazard,
	input exec_ctrl_t exec,
	input flow_ctrl_t flow
);

	// return is a single cycle pulse
	ret_pulse: assert property (@(posedge clk) flow.pc_ret |=> !flow.pc_ret)
		else $error("pc_ret high on two cycles running");

	// jump and call come from opposite values of bit 8
	jmp_call_excl: assert property (@(posedge clk) !(flow.pc_jmp && flow.pc_call))
		else $error("pc_jmp and pc_call high together");

	reset_idle: assert property (@(posedge clk) rst |=>
		(!exec.data_wren && !exec.data_ren && !exec.io_wren && !exec.io_ren &&
		!exec.status_ren && !exec.address_select && !exec.data_select &&
		!exec.io_select && !exec.regf_wren && exec.alu_op == ALU_NOP &&
		flow == 4'b0000))
		else $error("decode outputs not idle after reset");

	// back-pressure freezes the execute controls
	hazard_hold: assert property (@(posedge clk) (hazard && !rst) |=> $stable(exec))
		else $error("exec changed under hazard");

endmodule : decode_properties

bind decode_unit decode_properties u_decode_properties (
	.clk(clk),
	.rst(rst),
	.hazard(hazard),
	.exec(exec),
	.flow(flow)
);

//--- design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
	import decode_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic jmp_rst,
	input logic brx_rst,
	input logic input_flush,
	input logic output_flush,
	input logic hazard,
	input logic p_cache_miss,
	input instr_t prg_data,
	output exec_ctrl_t exec,
	output instr_fields_t fields,
	output flow_ctrl_t flow
);

	// word under decode, shared by both decoders
	instr_t cur_instr;

	// stage 1, fetch side
	// hazard replay and nop fill on cache miss
	instr_latch u_instr_latch (
		.clk(clk),
		.rst(rst),
		.input_flush(input_flush),
		.hazard(hazard),
		.p_cache_miss(p_cache_miss),
		.prg_data(prg_data),
		.cur_instr(cur_instr)
	);

	// stage 2, datapath controls
	operand_decode u_operand_decode (
		.clk(clk),
		.rst(rst),
		.hazard(hazard),
		.output_flush(output_flush),
		.cur_instr(cur_instr),
		.exec(exec),
		.fields(fields)
	);

	// stage 2, pc controls
	// cleared separately by fetch
	flow_decode u_flow_decode (
		.clk(clk),
		.rst(rst),
		.hazard(hazard),
		.output_flush(output_flush),
		.jmp_rst(jmp_rst),
		.brx_rst(brx_rst),
		.cur_instr(cur_instr),
		.flow(flow)
	);

endmodule : decode_unit

//--- design/flow_decode.sv
`timescale 1ns/1ps

`include "decode_params.svh"

module flow_decode
	import decode_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic hazard,
	input logic output_flush,
	input logic jmp_rst,
	input logic brx_rst,
	input instr_t cur_instr,
	output flow_ctrl_t flow
);

	logic [3:0] opcode;
	logic is_xfer;
	// next flag values before flush
	logic jmp_next;
	logic call_next;
	logic ret_next;
	logic brx_next;

	assign opcode = cur_instr[`DEC_INSTR_W-1 -: 4];
	assign is_xfer = (opcode == 4'hB);

	// opcode B with bits 9..8 picking the flavour
	// x1 jump, 00 call, 10 return
	assign jmp_next = is_xfer & cur_instr[8];
	assign call_next = is_xfer & ~cur_instr[8] & ~cur_instr[9];
	assign ret_next = is_xfer & ~cur_instr[8] & cur_instr[9];

	// D always branches
	// C only with a condition bit
	// the bare C word is the nop
	assign brx_next = (opcode == 4'hD) |
		((opcode == 4'hC) & (cur_instr[11] | cur_instr[10]));

	always_ff @(posedge clk)
	begin
		// jump and call cleared by fetch once taken
		// that clear acts even under hazard
		if (rst | jmp_rst)
		begin
			flow.pc_jmp <= 1'b0;
			flow.pc_call <= 1'b0;
		end
		else if (~hazard)
		begin
			flow.pc_jmp <= jmp_next & ~output_flush;
			flow.pc_call <= call_next & ~output_flush;
		end

		// branch has its own clear
		if (rst | brx_rst)
			flow.pc_brx <= 1'b0;
		else if (~hazard)
			flow.pc_brx <= brx_next & ~output_flush;

		// return is a single cycle pulse
		if (rst | flow.pc_ret)
			flow.pc_ret <= 1'b0;
		else if (~hazard)
			flow.pc_ret <= ret_next & ~output_flush;
	end

endmodule : flow_decode

//--- design/operand_decode.sv
`timescale 1ns/1ps

`include "decode_params.svh"

module operand_decode
	import decode_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic hazard,
	input logic output_flush,
	input instr_t cur_instr,
	output exec_ctrl_t exec,
	output instr_fields_t fields
);

	logic [3:0] opcode;
	// destination in bits 4..0, source in bits 9..5
	reg_addr_t dest_addr;
	reg_addr_t src_addr;
	exec_ctrl_t exec_idle;
	exec_ctrl_t exec_next;
	instr_fields_t fields_next;

	// opcodes 0..A in order
	function automatic alu_op_t alu_code(input logic [3:0] opc);
		alu_op_t code;
		case (opc)
			4'h0: code = ALU_ADD;
			4'h1: code = ALU_ADDC;
			4'h2: code = ALU_SUB;
			4'h3: code = ALU_SUBC;
			4'h4: code = ALU_MOVE;
			4'h5: code = ALU_NOT;
			4'h6: code = ALU_ROR;
			4'h7: code = ALU_ROL;
			4'h8: code = ALU_AND;
			4'h9: code = ALU_XOR;
			4'hA: code = ALU_OR;
			default: code = ALU_NOP;
		endcase
		return code;
	endfunction

	assign opcode = cur_instr[`DEC_INSTR_W-1 -: 4];
	assign dest_addr = cur_instr[4:0];
	assign src_addr = cur_instr[9:5];

	// fields go through untouched
	assign fields_next.i_field = cur_instr[`DEC_IMM_W-1:0];
	assign fields_next.h_en = cur_instr[11];
	assign fields_next.l_en = cur_instr[10];
	assign fields_next.src_raddr = src_addr;
	assign fields_next.pc_brxt = cur_instr[12];

	// quiet controls, last destination kept
	always_comb
	begin
		exec_idle = exec;
		exec_idle.data_wren = 1'b0;
		exec_idle.data_ren = 1'b0;
		exec_idle.io_wren = 1'b0;
		exec_idle.io_ren = 1'b0;
		exec_idle.status_ren = 1'b0;
		exec_idle.address_select = 1'b0;
		exec_idle.data_select = 1'b0;
		exec_idle.io_select = 1'b0;
		exec_idle.alu_op = ALU_NOP;
		exec_idle.regf_wren = 1'b0;
	end

	always_comb
	begin
		exec_next = exec_idle;
		exec_next.dest_waddr = dest_addr;
		case (opcode)
			// add addc sub subc move not ror rol and xor or
			4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8, 4'h9, 4'hA:
			begin
				exec_next.alu_op = alu_code(opcode);
				exec_next.regf_wren = 1'b1;
				exec_next.data_wren = (dest_addr == `DEC_REG_DATA);
				exec_next.io_wren = (dest_addr == `DEC_REG_IO);
				exec_next.address_select = (dest_addr == `DEC_REG_ADDR_LO) |
					(dest_addr == `DEC_REG_ADDR_HI);
				exec_next.data_select = (dest_addr == `DEC_REG_DSEL_LO) |
					(dest_addr == `DEC_REG_DSEL_HI);
				exec_next.io_select = (dest_addr == `DEC_REG_IOSEL);
				exec_next.data_ren = (src_addr == `DEC_REG_DATA);
				exec_next.io_ren = (src_addr == `DEC_REG_IO);
				exec_next.status_ren = (src_addr == `DEC_REG_STATUS);
			end
			// call, ret and jmp families, link written for the long forms
			4'hB:
			begin
				exec_next.dest_waddr = `DEC_REG_AUX1;
				exec_next.regf_wren = cur_instr[11] | cur_instr[10];
			end
			// nop and branches, flow_decode handles them
			4'hC, 4'hD:
			begin
				exec_next.regf_wren = 1'b0;
			end
			// lim into one of four immediate registers
			4'hE:
			begin
				exec_next.dest_waddr = {`DEC_LIM_BASE, cur_instr[9:8]};
				exec_next.regf_wren = 1'b1;
			end
			// bitt reads a source only
			4'hF:
			begin
				exec_next.alu_op = ALU_BITT;
				exec_next.data_ren = (src_addr == `DEC_REG_DATA);
				exec_next.io_ren = (src_addr == `DEC_REG_IO);
				exec_next.status_ren = (src_addr == `DEC_REG_STATUS);
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		// reset wins over hazard
		if (rst)
			exec <= exec_idle;
		else if (~hazard)
		begin
			if (output_flush)
				exec <= exec_idle;
			else
			begin
				exec <= exec_next;
				fields <= fields_next;
			end
		end
	end

endmodule : operand_decode

//--- design/instr_latch.sv
`timescale 1ns/1ps

`include "decode_params.svh"

module instr_latch
	import decode_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic input_flush,
	input logic hazard,
	input logic p_cache_miss,
	input instr_t prg_data,
	output instr_t cur_instr
);

	// word fetched on the first hazard cycle
	instr_t alt_instr;
	// hazard and miss seen last cycle
	logic hazard_q;
	logic miss_q;
	// miss now or one cycle ago
	logic miss_any;
	logic hazard_start;
	logic hazard_end;

	assign miss_any = p_cache_miss | miss_q;
	assign hazard_start = hazard & ~hazard_q;
	assign hazard_end = ~hazard & hazard_q;

	always_ff @(posedge clk)
	begin
		if (rst | input_flush)
		begin
			cur_instr <= `DEC_NOP_WORD;
			alt_instr <= `DEC_NOP_WORD;
			hazard_q <= 1'b0;
			miss_q <= 1'b0;
		end
		else
		begin
			miss_q <= p_cache_miss;
			// hazard history frozen during a miss, but a falling hazard always gets through
			if (~miss_any | hazard_end)
				hazard_q <= hazard;
			// prg_data still valid on the first hazard cycle, keep it for replay
			if (hazard_start)
				alt_instr <= prg_data;
			// current word holds while hazard is up
			if (~hazard)
			begin
				if (hazard_q)
					cur_instr <= alt_instr;
				else if (miss_any)
					cur_instr <= `DEC_NOP_WORD;
				else
					cur_instr <= prg_data;
			end
		end
	end

endmodule : instr_latch

//--- design/decode_pkg.sv
package decode_pkg;

	`include "decode_params.svh"

	// raw instruction word from the program cache
	typedef logic [`DEC_INSTR_W-1:0] instr_t;

	// register file address
	typedef logic [`DEC_REG_ADDR_W-1:0] reg_addr_t;

	// immediate field, low ten bits of the word
	typedef logic [`DEC_IMM_W-1:0] imm_t;

	// alu operation codes
	// bit 3 selects the carry or inverted variant
	typedef enum logic [`DEC_ALU_OP_W-1:0] {
		ALU_ADD  = 4'h0,
		ALU_ADDC = 4'h8,
		ALU_SUB  = 4'h1,
		ALU_SUBC = 4'h9,
		ALU_MOVE = 4'h2,
		ALU_NOT  = 4'hA,
		ALU_ROR  = 4'h3,
		ALU_ROL  = 4'hB,
		ALU_AND  = 4'h4,
		ALU_XOR  = 4'h5,
		ALU_OR   = 4'h6,
		ALU_NOP  = 4'h7,
		ALU_BITT = 4'hF
	} alu_op_t;

	// execute stage controls
	typedef struct packed {
		logic data_wren;
		logic data_ren;
		logic io_wren;
		logic io_ren;
		logic status_ren;
		logic address_select;
		logic data_select;
		logic io_select;
		alu_op_t alu_op;
		logic regf_wren;
		// only valid with regf_wren
		reg_addr_t dest_waddr;
	} exec_ctrl_t;

	// raw fields passed on to later stages
	typedef struct packed {
		imm_t i_field;
		logic h_en;
		logic l_en;
		reg_addr_t src_raddr;
		logic pc_brxt;
	} instr_fields_t;

	// program counter requests
	typedef struct packed {
		logic pc_jmp;
		logic pc_brx;
		logic pc_call;
		logic pc_ret;
	} flow_ctrl_t;

endpackage : decode_pkg

//--- design/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// instruction word and its fields
`define DEC_INSTR_W 16
`define DEC_REG_ADDR_W 5
`define DEC_IMM_W 10

// alu operation code width
`define DEC_ALU_OP_W 4

// opcode C with no condition bits, decodes to nothing
`define DEC_NOP_WORD 16'hC000

// memory-mapped ports in the register file
`define DEC_REG_DATA 5'h18
`define DEC_REG_IO 5'h19
`define DEC_REG_STATUS 5'h1E

// address pointer pair
`define DEC_REG_ADDR_LO 5'h1A
`define DEC_REG_ADDR_HI 5'h1B

// data select pair
`define DEC_REG_DSEL_LO 5'h14
`define DEC_REG_DSEL_HI 5'h15

// io select
`define DEC_REG_IOSEL 5'h16

// link register for call and jump with link
`define DEC_REG_AUX1 5'h11

// lim targets 10..13, low two bits from the instruction
`define DEC_LIM_BASE 3'b100

`endif
